/* rtl/core_pkg.sv */
// shared types and constants of the rhythm game sequencing core
package core_pkg;

	localparam int ADDR_W = 13; // BRAM address width
	localparam int LANES = 4;

	typedef logic [23:0] db_word_t; // beatmap word
	typedef logic [31:0] dp_word_t; // pixel word
	typedef logic [ADDR_W-1:0] tbl_addr_t;

	// stream aux_info codes
	localparam logic [7:0] TBL_DB = 8'd0;
	localparam logic [7:0] TBL_DP = 8'd2;

	typedef enum logic [3:0] {
		INIT,
		LOAD_DB,
		W_LOAD_DB,
		LOAD_DP,
		W_LOAD_DP,
		SCAN_DB,
		W_SCAN_DB,
		SCAN_DP,
		W_SCAN_DP,
		PLAY
	} phase_t;

	typedef struct packed {
		tbl_addr_t [LANES-1:0] size;
		tbl_addr_t [LANES-1:0] base;
	} lane_table_t;

	// request side of the storage stream
	typedef struct packed {
		logic [7:0] init_index;
		logic [7:0] aux_info;
		logic       request_data;
		logic       restart;
	} pre_req_t;

	typedef struct packed {
		tbl_addr_t addr;
		db_word_t  data;
		logic      en;
	} db_wr_t;

	typedef struct packed {
		tbl_addr_t addr;
		dp_word_t  data;
		logic      en;
	} dp_wr_t;

	typedef struct packed {
		tbl_addr_t addr;
		logic      en;
	} rd_req_t;

endpackage

/* rtl/table_loader.sv */
// table loader, packs storage stream bytes into words and writes one table BRAM
`timescale 1ns/10ps

module table_loader import core_pkg::*; #(
	parameter type word_t = db_word_t,
	parameter logic [7:0] TBL_CODE = TBL_DB
) (
	input  logic       CLK,
	input  logic       RESET_L,
	input  logic       start,
	input  logic [7:0] song_selection,
	input  logic [7:0] pre_data,
	input  logic       pre_data_ready,
	input  logic       pre_transmit_finished,
	output pre_req_t   req,
	output tbl_addr_t  wr_addr,
	output word_t      wr_data,
	output logic       wr_en,
	output logic       done
);

	localparam int W = $bits(word_t);
	localparam int BYTES = W / 8;
	localparam int BC_W = $clog2(BYTES);

	typedef enum logic [1:0] {L_IDLE, L_RESTART, L_REQ, L_WAIT} ld_state_t;

	ld_state_t state;
	logic [BC_W-1:0] byte_cnt;
	logic last_byte;
	word_t word_q;
	tbl_addr_t addr_q;

	assign last_byte = byte_cnt == BC_W'(BYTES - 1);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= L_IDLE;
			byte_cnt <= '0;
			addr_q <= '0;
			wr_en <= 1'b0;
			done <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			done <= 1'b0;
			if (wr_en)
				addr_q <= addr_q + 1'b1; // next word slot
			case (state)
				L_IDLE: begin
					if (start)
						state <= L_RESTART;
				end
				L_RESTART: begin
					state <= L_REQ;
					byte_cnt <= '0;
					addr_q <= '0;
				end
				L_REQ: state <= L_WAIT;
				L_WAIT: begin
					if (pre_data_ready) begin
						state <= L_REQ;
						byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
						wr_en <= last_byte;
					end else if (pre_transmit_finished) begin
						state <= L_IDLE; // partial word dropped
						done <= 1'b1;
					end
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	// lsb first, the newest byte enters at the top
	always_ff @(posedge CLK) begin
		if (state == L_WAIT && pre_data_ready)
			word_q <= {pre_data, word_q[W-1:8]};
	end

	always_comb begin
		req = '0;
		req.restart = state == L_RESTART;
		req.request_data = state == L_REQ;
		if (state == L_RESTART) begin
			req.init_index = song_selection;
			req.aux_info = TBL_CODE;
		end
	end

	assign wr_addr = addr_q;
	assign wr_data = word_q;

	a_no_write_idle: assert property (@(posedge CLK) disable iff (!RESET_L)
		$rose(wr_en) |-> state != L_IDLE);

endmodule

/* rtl/header_scanner.sv */
// header scanner, walks the four lane headers of one table and builds its lane table
`timescale 1ns/10ps

module header_scanner import core_pkg::*; #(
	parameter type word_t = db_word_t
) (
	input  logic        CLK,
	input  logic        RESET_L,
	input  logic        start,
	input  word_t       rd_data,
	output rd_req_t     rd,
	output lane_table_t lanes,
	output logic        done
);

	localparam int LANE_W = $clog2(LANES);

	logic active;
	logic [LANE_W-1:0] lane;
	logic [1:0] slot; // 4 cycle read slot
	logic rd_en_q;
	tbl_addr_t rd_addr_q;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			active <= 1'b0;
			lane <= '0;
			slot <= '0;
			rd_en_q <= 1'b0;
			done <= 1'b0;
			lanes <= '0;
		end else begin
			done <= 1'b0;
			if (!active) begin
				if (start) begin
					active <= 1'b1;
					lane <= '0;
					slot <= '0;
				end
			end else begin
				slot <= slot + 1'b1;
				case (slot)
					2'd0: rd_en_q <= 1'b1;
					2'd3: begin
						rd_en_q <= 1'b0;
						lanes.size[lane] <= rd_data[ADDR_W-1:0];
						lanes.base[lane] <= rd_addr_q + 1'b1; // body follows its header
						lane <= lane + 1'b1;
						if (lane == LANE_W'(LANES - 1)) begin
							active <= 1'b0;
							done <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// header of lane k sits right after the body of lane k-1
	always_ff @(posedge CLK) begin
		if (active && slot == 2'd0)
			rd_addr_q <= (lane == '0) ? '0 :
				lanes.base[lane - 1'b1] + lanes.size[lane - 1'b1];
	end

	assign rd = '{addr: rd_addr_q, en: rd_en_q};

	a_rd_idle: assert property (@(posedge CLK) disable iff (!RESET_L)
		!active |-> !rd.en);

endmodule

/* rtl/play_timer.sv */
// play timer, update, audio and draw ticks plus the delayed song sample requests
`timescale 1ns/10ps

module play_timer #(
	parameter int UPDATE_PERIOD = 100000,
	parameter int AUDIO_PERIOD = 2267,
	parameter int DRAW_PERIOD = 1680000,
	parameter int PLAY_DELAY = 66150
) (
	input  logic       CLK,
	input  logic       RESET_L,
	input  logic       play,
	input  logic [7:0] song_data_in,
	input  logic       song_data_ready,
	output logic       update_tick,
	output logic       draw_tick,
	output logic       song_request_data,
	output logic [7:0] main_audio_out,
	output logic       audio_en
);

	localparam int UPD_W = $clog2(UPDATE_PERIOD + 1);
	localparam int AUD_W = $clog2(AUDIO_PERIOD + 1);
	localparam int DRW_W = $clog2(DRAW_PERIOD + 1);
	localparam int DLY_W = $clog2(PLAY_DELAY + 1);

	logic [UPD_W-1:0] upd_cnt;
	logic [AUD_W-1:0] aud_cnt;
	logic [DRW_W-1:0] drw_cnt;
	logic [DLY_W-1:0] delay_cnt; // saturates at PLAY_DELAY
	logic upd_wrap, aud_wrap, drw_wrap, delay_full;

	assign upd_wrap = upd_cnt == UPD_W'(UPDATE_PERIOD - 1);
	assign aud_wrap = aud_cnt == AUD_W'(AUDIO_PERIOD - 1);
	assign drw_wrap = drw_cnt == DRW_W'(DRAW_PERIOD - 1);
	assign delay_full = delay_cnt == DLY_W'(PLAY_DELAY);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			upd_cnt <= '0;
			aud_cnt <= '0;
			drw_cnt <= '0;
			delay_cnt <= '0;
			update_tick <= 1'b0;
			draw_tick <= 1'b0;
			song_request_data <= 1'b0;
			main_audio_out <= '0;
		end else begin
			if (play) begin
				upd_cnt <= upd_wrap ? '0 : upd_cnt + 1'b1;
				aud_cnt <= aud_wrap ? '0 : aud_cnt + 1'b1;
				drw_cnt <= drw_wrap ? '0 : drw_cnt + 1'b1;
				if (aud_wrap && !delay_full)
					delay_cnt <= delay_cnt + 1'b1;
			end
			update_tick <= play && upd_wrap;
			draw_tick <= play && drw_wrap;
			song_request_data <= play && aud_wrap && delay_full;
			if (song_data_ready)
				main_audio_out <= song_data_in; // latched in any phase
		end
	end

	assign audio_en = play;

	a_req_after_delay: assert property (@(posedge CLK) disable iff (!RESET_L)
		song_request_data |-> $past(delay_full));

endmodule

/* rtl/core_sequencer.sv */
// phase FSM of the core and owner mux of the storage stream
`timescale 1ns/10ps

module core_sequencer import core_pkg::*; (
	input  logic     CLK,
	input  logic     RESET_L,
	input  pre_req_t db_req,
	input  pre_req_t dp_req,
	input  logic     db_load_done,
	input  logic     dp_load_done,
	input  logic     db_scan_done,
	input  logic     dp_scan_done,
	output phase_t   phase,
	output logic     db_load_start,
	output logic     dp_load_start,
	output logic     db_scan_start,
	output logic     dp_scan_start,
	output logic     play,
	output pre_req_t pre_req
);

	phase_t phase_nxt;

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			phase <= INIT;
		else
			phase <= phase_nxt;
	end

	always_comb begin
		case (phase)
			INIT:      phase_nxt = LOAD_DB;
			LOAD_DB:   phase_nxt = W_LOAD_DB;
			W_LOAD_DB: phase_nxt = db_load_done ? LOAD_DP : W_LOAD_DB;
			LOAD_DP:   phase_nxt = W_LOAD_DP;
			W_LOAD_DP: phase_nxt = dp_load_done ? SCAN_DB : W_LOAD_DP;
			SCAN_DB:   phase_nxt = W_SCAN_DB;
			W_SCAN_DB: phase_nxt = db_scan_done ? SCAN_DP : W_SCAN_DB;
			SCAN_DP:   phase_nxt = W_SCAN_DP;
			W_SCAN_DP: phase_nxt = dp_scan_done ? PLAY : W_SCAN_DP;
			PLAY:      phase_nxt = PLAY; // stays until reset
			default:   phase_nxt = INIT;
		endcase
	end

	assign db_load_start = phase == LOAD_DB;
	assign dp_load_start = phase == LOAD_DP;
	assign db_scan_start = phase == SCAN_DB;
	assign dp_scan_start = phase == SCAN_DP;
	assign play = phase == PLAY;

	// stream belongs to the loader of the current load phase
	always_comb begin
		case (phase)
			LOAD_DB, W_LOAD_DB: pre_req = db_req;
			LOAD_DP, W_LOAD_DP: pre_req = dp_req;
			default:            pre_req = '0;
		endcase
	end

	a_play_sticky: assert property (@(posedge CLK) disable iff (!RESET_L)
		phase == PLAY |=> phase == PLAY);

endmodule

/* rtl/core_top.sv */
// top of the rhythm game sequencing core, table loading, header scan and play timing
`timescale 1ns/10ps

module core_top import core_pkg::*; #(
	parameter int UPDATE_PERIOD = 100000,
	parameter int AUDIO_PERIOD = 2267,
	parameter int DRAW_PERIOD = 1680000,
	parameter int PLAY_DELAY = 66150
) (
	input  logic        CLK,
	input  logic        RESET_L,
	input  logic [7:0]  song_selection,
	// storage stream
	output pre_req_t    pre_req,
	input  logic [7:0]  pre_data,
	input  logic        pre_data_ready,
	input  logic        pre_transmit_finished,
	// BRAM ports
	output db_wr_t      db_wr,
	output dp_wr_t      dp_wr,
	output rd_req_t     db_rd,
	output rd_req_t     dp_rd,
	input  db_word_t    db_rd_data,
	input  dp_word_t    dp_rd_data,
	// audio
	output logic        song_request_data,
	input  logic [7:0]  song_data_in,
	input  logic        song_data_ready,
	output logic [7:0]  main_audio_out,
	output logic        audio_en,
	output logic        update_tick,
	output logic        draw_tick,
	output lane_table_t db_lanes,
	output lane_table_t dp_lanes,
	output phase_t      debug_phase
);

	pre_req_t db_req, dp_req;
	logic db_load_start, dp_load_start, db_scan_start, dp_scan_start;
	logic db_load_done, dp_load_done, db_scan_done, dp_scan_done;
	logic play;
	tbl_addr_t db_wr_addr, dp_wr_addr;
	db_word_t db_wr_data;
	dp_word_t dp_wr_data;
	logic db_wr_en, dp_wr_en;

	core_sequencer u_seq (
		.CLK(CLK), .RESET_L(RESET_L),
		.db_req(db_req), .dp_req(dp_req),
		.db_load_done(db_load_done), .dp_load_done(dp_load_done),
		.db_scan_done(db_scan_done), .dp_scan_done(dp_scan_done),
		.phase(debug_phase),
		.db_load_start(db_load_start), .dp_load_start(dp_load_start),
		.db_scan_start(db_scan_start), .dp_scan_start(dp_scan_start),
		.play(play), .pre_req(pre_req)
	);

	table_loader #(.word_t(db_word_t), .TBL_CODE(TBL_DB)) u_load_db (
		.CLK(CLK), .RESET_L(RESET_L), .start(db_load_start),
		.song_selection(song_selection), .pre_data(pre_data),
		.pre_data_ready(pre_data_ready), .pre_transmit_finished(pre_transmit_finished),
		.req(db_req), .wr_addr(db_wr_addr), .wr_data(db_wr_data),
		.wr_en(db_wr_en), .done(db_load_done)
	);

	table_loader #(.word_t(dp_word_t), .TBL_CODE(TBL_DP)) u_load_dp (
		.CLK(CLK), .RESET_L(RESET_L), .start(dp_load_start),
		.song_selection(song_selection), .pre_data(pre_data),
		.pre_data_ready(pre_data_ready), .pre_transmit_finished(pre_transmit_finished),
		.req(dp_req), .wr_addr(dp_wr_addr), .wr_data(dp_wr_data),
		.wr_en(dp_wr_en), .done(dp_load_done)
	);

	assign db_wr = '{addr: db_wr_addr, data: db_wr_data, en: db_wr_en};
	assign dp_wr = '{addr: dp_wr_addr, data: dp_wr_data, en: dp_wr_en};

	header_scanner #(.word_t(db_word_t)) u_scan_db (
		.CLK(CLK), .RESET_L(RESET_L), .start(db_scan_start),
		.rd_data(db_rd_data), .rd(db_rd), .lanes(db_lanes), .done(db_scan_done)
	);

	header_scanner #(.word_t(dp_word_t)) u_scan_dp (
		.CLK(CLK), .RESET_L(RESET_L), .start(dp_scan_start),
		.rd_data(dp_rd_data), .rd(dp_rd), .lanes(dp_lanes), .done(dp_scan_done)
	);

	play_timer #(
		.UPDATE_PERIOD(UPDATE_PERIOD),
		.AUDIO_PERIOD(AUDIO_PERIOD),
		.DRAW_PERIOD(DRAW_PERIOD),
		.PLAY_DELAY(PLAY_DELAY)
	) u_timer (
		.CLK(CLK), .RESET_L(RESET_L), .play(play),
		.song_data_in(song_data_in), .song_data_ready(song_data_ready),
		.update_tick(update_tick), .draw_tick(draw_tick),
		.song_request_data(song_request_data),
		.main_audio_out(main_audio_out), .audio_en(audio_en)
	);

endmodule

/* test/tb_models.sv */
// storage stream and BRAM models for the core testbench
`timescale 1ns/10ps

module stream_model import core_pkg::*; (
	input  logic       CLK,
	input  pre_req_t   pre_req,
	output logic [7:0] pre_data,
	output logic       pre_data_ready,
	output logic       pre_transmit_finished
);

	logic [7:0] db_img [0:127]; // filled by the testbench
	logic [7:0] dp_img [0:127];
	int db_len;
	int dp_len;
	integer seed = 32'h2f94;
	logic [7:0] sel = TBL_DB;
	int idx = 0;
	int len;
	int wait_cnt = 0; // cycles until the pending answer

	initial begin
		pre_data = '0;
		pre_data_ready = 1'b0;
		pre_transmit_finished = 1'b0;
	end

	always @(posedge CLK) begin
		pre_data_ready <= #1 1'b0;
		pre_transmit_finished <= #1 1'b0;
		if (pre_req.restart) begin
			sel = pre_req.aux_info;
			idx = 0;
		end
		if (pre_req.request_data) begin
			wait_cnt = 1 + int'($unsigned($random(seed)) % 3);
		end else if (wait_cnt > 0) begin
			wait_cnt = wait_cnt - 1;
			len = (sel == TBL_DP) ? dp_len : db_len;
			if (wait_cnt == 0 && idx < len) begin
				pre_data <= #1 (sel == TBL_DP) ? dp_img[idx] : db_img[idx];
				pre_data_ready <= #1 1'b1;
				idx = idx + 1;
			end else if (wait_cnt == 0) begin
				pre_transmit_finished <= #1 1'b1; // image exhausted
			end
		end
	end

endmodule

module bram_model import core_pkg::*; #(
	parameter type word_t = logic [23:0]
) (
	input  logic      CLK,
	input  logic      we,
	input  tbl_addr_t waddr,
	input  word_t     wdata,
	input  logic      re,
	input  tbl_addr_t raddr,
	output word_t     rdata
);

	word_t mem [0:(1 << ADDR_W) - 1];

	initial rdata = '0;

	always @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;
		if (re)
			rdata <= #1 mem[raddr]; // one cycle read latency
	end

endmodule

/* test/tb_core.sv */
// testbench of the sequencing core, loads two tables, scans them and watches play timing
`timescale 1ns/10ps

module tb_core import core_pkg::*; ();

	localparam int UPD = 20;
	localparam int AUD = 7;
	localparam int DRW = 50;
	localparam int DLY = 3;
	localparam int PLAY_WIN = 200;
	localparam logic [7:0] SONG = 8'h5c;

	logic CLK = 1'b0;
	logic RESET_L;
	logic [7:0] song_selection;
	logic [7:0] song_data_in;
	logic song_data_ready;
	logic [7:0] pre_data, main_audio_out;
	logic pre_data_ready, pre_transmit_finished;
	logic song_request_data, audio_en, update_tick, draw_tick;
	pre_req_t pre_req;
	db_wr_t db_wr;
	dp_wr_t dp_wr;
	rd_req_t db_rd, dp_rd;
	db_word_t db_rd_data;
	dp_word_t dp_rd_data;
	lane_table_t db_lanes, dp_lanes, exp_db, exp_dp;
	phase_t debug_phase;

	db_word_t db_exp [0:31];
	dp_word_t dp_exp [0:31];
	int db_n, dp_n, db_writes = 0, dp_writes = 0, restarts = 0, sreqs = 0;
	int db_sizes [4] = '{2, 1, 3, 0};
	int dp_sizes [4] = '{1, 0, 2, 1};
	int cyc = 0, pc = 0, limit = 0, total = 0, failed = 0;
	int err [5] = '{0, 0, 0, 0, 0};
	string names [5] = '{"reset", "load", "scan", "ticks", "audio"};
	logic rst_q = 1'b1;
	logic in_play;
	logic upd_due, drw_due, sreq_due;
	logic [7:0] exp_code;

	core_top #(.UPDATE_PERIOD(UPD), .AUDIO_PERIOD(AUD), .DRAW_PERIOD(DRW), .PLAY_DELAY(DLY))
	u_core_top (.*);

	stream_model u_stream (.CLK(CLK), .pre_req(pre_req), .pre_data(pre_data),
		.pre_data_ready(pre_data_ready), .pre_transmit_finished(pre_transmit_finished));
	bram_model #(.word_t(db_word_t)) u_db_ram (.CLK(CLK), .we(db_wr.en), .waddr(db_wr.addr),
		.wdata(db_wr.data), .re(db_rd.en), .raddr(db_rd.addr), .rdata(db_rd_data));
	bram_model #(.word_t(dp_word_t)) u_dp_ram (.CLK(CLK), .we(dp_wr.en), .waddr(dp_wr.addr),
		.wdata(dp_wr.data), .re(dp_rd.en), .raddr(dp_rd.addr), .rdata(dp_rd_data));

	assign in_play = debug_phase == PLAY;

	// beatmap is loaded first, pixels second
	assign exp_code = (restarts == 0) ? TBL_DB : TBL_DP;

	assign upd_due = in_play && pc != 0 && pc % UPD == 0;
	assign drw_due = in_play && pc != 0 && pc % DRW == 0;
	assign sreq_due = in_play && pc >= AUD * (DLY + 1) && pc % AUD == 0;

	initial begin
		forever #50 CLK = ~CLK;
	end

	// header word per lane, then its body, headers carry junk above the size
	task automatic build_tables();
		db_n = 0;
		dp_n = 0;
		for (int l = 0; l < LANES; l++) begin
			db_exp[db_n] = db_word_t'(32'hfe0000 | db_sizes[l]);
			exp_db.size[l] = tbl_addr_t'(db_sizes[l]);
			exp_db.base[l] = tbl_addr_t'(db_n + 1);
			db_n++;
			for (int j = 0; j < db_sizes[l]; j++) begin
				db_exp[db_n] = db_word_t'(32'h3c0000 + db_n * 32'h0101);
				db_n++;
			end
			dp_exp[dp_n] = dp_word_t'(32'hc0de0000 | dp_sizes[l]);
			exp_dp.size[l] = tbl_addr_t'(dp_sizes[l]);
			exp_dp.base[l] = tbl_addr_t'(dp_n + 1);
			dp_n++;
			for (int j = 0; j < dp_sizes[l]; j++) begin
				dp_exp[dp_n] = 32'h9a000000 + dp_n * 32'h01030507;
				dp_n++;
			end
		end
		for (int w = 0; w < db_n; w++)
			for (int b = 0; b < 3; b++)
				u_stream.db_img[w * 3 + b] = db_exp[w][8 * b +: 8];
		for (int w = 0; w < dp_n; w++)
			for (int b = 0; b < 4; b++)
				u_stream.dp_img[w * 4 + b] = dp_exp[w][8 * b +: 8];
		u_stream.db_img[db_n * 3] = 8'hee; // trailing partial words
		u_stream.dp_img[dp_n * 4] = 8'h11;
		u_stream.dp_img[dp_n * 4 + 1] = 8'h22;
		u_stream.db_len = db_n * 3 + 1;
		u_stream.dp_len = dp_n * 4 + 2;
	endtask

	always @(posedge CLK) begin
		cyc <= cyc + 1;
		rst_q <= !RESET_L;
		if (in_play)
			pc <= pc + 1;
		if (db_wr.en)
			db_writes <= db_writes + 1;
		if (dp_wr.en)
			dp_writes <= dp_writes + 1;
		if (pre_req.restart)
			restarts <= restarts + 1;
		if (song_request_data)
			sreqs <= sreqs + 1;
		if (limit > 0 && cyc > limit) begin
			$display("timeout: run did not reach its end within %0d cycles", limit);
			$display("Finished with errors");
			$finish;
		end
	end

	// sample source answers one cycle after each request
	always @(posedge CLK) begin
		song_data_ready <= #1 song_request_data;
		if (song_request_data)
			song_data_in <= #1 song_data_in + 8'h13;
	end

	a_quiet: assert property (@(posedge CLK) (cyc > 0 && (!RESET_L || rst_q)) |->
		(!db_wr.en && !dp_wr.en && !db_rd.en && !dp_rd.en && pre_req == '0 && !audio_en &&
		!song_request_data && !update_tick && !draw_tick && debug_phase == INIT &&
		db_lanes == '0 && dp_lanes == '0))
		else begin
			err[0]++;
			$display("reset: outputs not quiet in or right after reset");
		end

	a_index: assert property (@(posedge CLK) disable iff (!RESET_L)
		pre_req.restart |-> pre_req.init_index == SONG)
		else begin
			err[1]++;
			$display("mismatch load expected %h actual %h", SONG, pre_req.init_index);
		end
	a_code: assert property (@(posedge CLK) disable iff (!RESET_L)
		pre_req.restart |-> pre_req.aux_info == exp_code)
		else begin
			err[1]++;
			$display("mismatch load expected %h actual %h", $sampled(exp_code),
				$sampled(pre_req.aux_info));
		end
	a_db_addr: assert property (@(posedge CLK) disable iff (!RESET_L)
		db_wr.en |-> int'(db_wr.addr) < db_n)
		else begin
			err[1]++;
			$display("load: beatmap write beyond the last whole word");
		end
	a_db_data: assert property (@(posedge CLK) disable iff (!RESET_L)
		db_wr.en |-> db_wr.data == db_exp[db_wr.addr[4:0]])
		else begin
			err[1]++;
			$display("mismatch load expected %h actual %h",
				db_exp[db_wr.addr[4:0]], db_wr.data);
		end
	a_dp_addr: assert property (@(posedge CLK) disable iff (!RESET_L)
		dp_wr.en |-> int'(dp_wr.addr) < dp_n)
		else begin
			err[1]++;
			$display("load: pixel write beyond the last whole word");
		end
	a_dp_data: assert property (@(posedge CLK) disable iff (!RESET_L)
		dp_wr.en |-> dp_wr.data == dp_exp[dp_wr.addr[4:0]])
		else begin
			err[1]++;
			$display("mismatch load expected %h actual %h",
				dp_exp[dp_wr.addr[4:0]], dp_wr.data);
		end

	a_db_lanes: assert property (@(posedge CLK) disable iff (!RESET_L)
		$rose(in_play) |-> db_lanes == exp_db)
		else begin
			err[2]++;
			$display("mismatch scan expected %h actual %h", exp_db, db_lanes);
		end
	a_dp_lanes: assert property (@(posedge CLK) disable iff (!RESET_L)
		$rose(in_play) |-> dp_lanes == exp_dp)
		else begin
			err[2]++;
			$display("mismatch scan expected %h actual %h", exp_dp, dp_lanes);
		end

	a_upd: assert property (@(posedge CLK) disable iff (!RESET_L)
		update_tick == upd_due)
		else begin
			err[3]++;
			$display("mismatch ticks expected %b actual %b at update play cycle %0d",
				$sampled(upd_due), $sampled(update_tick), $sampled(pc));
		end
	a_drw: assert property (@(posedge CLK) disable iff (!RESET_L)
		draw_tick == drw_due)
		else begin
			err[3]++;
			$display("mismatch ticks expected %b actual %b at draw play cycle %0d",
				$sampled(drw_due), $sampled(draw_tick), $sampled(pc));
		end

	a_sreq: assert property (@(posedge CLK) disable iff (!RESET_L)
		song_request_data == sreq_due)
		else begin
			err[4]++;
			$display("mismatch audio expected %b actual %b at request play cycle %0d",
				$sampled(sreq_due), $sampled(song_request_data), $sampled(pc));
		end
	a_sample: assert property (@(posedge CLK) disable iff (!RESET_L || rst_q)
		$past(song_data_ready) |-> main_audio_out == $past(song_data_in))
		else begin
			err[4]++;
			$display("mismatch audio expected %h actual %h",
				$past(song_data_in), main_audio_out);
		end
	a_aen: assert property (@(posedge CLK) disable iff (!RESET_L)
		audio_en == in_play)
		else begin
			err[4]++;
			$display("mismatch audio expected %b actual %b for audio_en",
				$sampled(in_play), $sampled(audio_en));
		end

	initial begin
		RESET_L = 1'b0;
		song_selection = SONG;
		song_data_in = 8'h40;
		song_data_ready = 1'b0;
		build_tables();
		limit = (u_stream.db_len + u_stream.dp_len) * 5 + 100 + PLAY_WIN;
		repeat (5) @(posedge CLK);
		#1 RESET_L = 1'b1;
		wait (debug_phase == PLAY);
		repeat (PLAY_WIN) @(posedge CLK);
		#1;
		if (restarts != 2 || db_writes != db_n || dp_writes != dp_n) begin
			err[1]++;
			$display("load: %0d restarts and %0d/%0d words written", restarts,
				db_writes, dp_writes);
		end
		if (sreqs == 0) begin
			err[4]++;
			$display("audio: no sample was requested in play");
		end
		for (int t = 0; t < 5; t++) begin
			$display("test %s done, %0d errors", names[t], err[t]);
			total += err[t];
			if (err[t] != 0)
				failed++;
		end
		$display("totals: 5 tests, %0d failed, %0d errors", failed, total);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* tb.f */
rtl/core_pkg.sv
rtl/table_loader.sv
rtl/header_scanner.sv
rtl/play_timer.sv
rtl/core_sequencer.sv
rtl/core_top.sv
test/tb_models.sv
test/tb_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_core -o tb_core_sim
	./obj_dir/tb_core_sim | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
